// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_jpg
FILELIST = src.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BIN)

clean:
	rm -rf $(BUILD)

// ==== source/axis_output_stage.sv ====
module axis_output_stage (
    input  logic               M_AXIS_ACLK,
    input  logic               M_AXIS_ARESETN,
    input  jpg_pkg::out_word_t word,
    input  logic               word_valid,
    input  logic               m_tready,
    output logic               word_taken,
    output logic               m_tvalid,
    output jpg_pkg::word_t     m_tdata,
    output logic               m_tlast
);

    jpg_pkg::os_state_t state;
    logic [$clog2(jpg_pkg::start_delay)-1:0] delay_count;

    assign word_taken = (state == jpg_pkg::accept) && word_valid;
    // valid stays up for the whole present phase
    assign m_tvalid = (state == jpg_pkg::present);

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            state <= jpg_pkg::delay;
            delay_count <= '0;
        end else begin
            unique case (state)
                jpg_pkg::delay: begin
                    if (32'(delay_count) == jpg_pkg::start_delay - 1) begin
                        state <= jpg_pkg::accept;
                    end else begin
                        delay_count <= delay_count + 1'b1;
                    end
                end
                jpg_pkg::accept: begin
                    if (word_valid) begin
                        state <= jpg_pkg::present;
                    end
                end
                default: begin
                    if (m_tready) begin
                        state <= jpg_pkg::accept;
                    end
                end
            endcase
        end
    end

    // output word, frozen while presented
    always_ff @(posedge M_AXIS_ACLK) begin
        if (word_taken) begin
            m_tdata <= word.data;
            m_tlast <= word.last;
        end
    end

endmodule

// ==== source/jpg_pkg.sv ====
package jpg_pkg;

    // block geometry
    localparam int block_side = 8;
    localparam int pixel_count = block_side * block_side;
    localparam int pixel_width = 8;
    localparam int word_width = 32;
    localparam int pixels_per_word = word_width / pixel_width;

    // idle cycles before the output stage takes its first word
    localparam int start_delay = 32;

    // luma weights, scaled by 2**luma_shift
    localparam int luma_coef_r = 77;
    localparam int luma_coef_g = 150;
    localparam int luma_coef_b = 29;
    localparam int luma_shift = 8;

    typedef logic [pixel_width-1:0] pixel_t;
    typedef logic [word_width-1:0] word_t;
    // one bit wider than a slot, so it can hold pixel_count itself
    typedef logic [$clog2(pixel_count):0] pixel_index_t;
    typedef pixel_t [pixel_count-1:0] plane_t;

    typedef struct packed {
        plane_t r;
        plane_t g;
        plane_t b;
    } rgb_block_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } out_word_t;

    typedef enum logic [1:0] {recv_r, recv_g, recv_b, hold} rx_state_t;
    typedef enum logic [1:0] {idle, convert, offer} cv_state_t;
    typedef enum logic {empty, sending} ser_state_t;
    typedef enum logic [1:0] {delay, accept, present} os_state_t;

endpackage

// ==== source/jpg_top.sv ====
module jpg_top (
    input  logic           M_AXIS_ACLK,
    input  logic           M_AXIS_ARESETN,
    input  jpg_pkg::word_t s_tdata,
    input  logic           s_tvalid,
    input  logic           s_tlast,
    input  logic           m_tready,
    output logic           s_tready,
    output logic           m_tvalid,
    output jpg_pkg::word_t m_tdata,
    output logic           m_tlast
);

    logic                block_full;
    logic                block_release;
    jpg_pkg::rgb_block_t block;
    logic                luma_full;
    logic                luma_taken;
    jpg_pkg::plane_t     luma;
    logic                word_valid;
    logic                word_taken;
    jpg_pkg::out_word_t  word;

    rgb_block_receiver u_receiver (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .s_tdata        (s_tdata),
        .s_tvalid       (s_tvalid),
        .s_tlast        (s_tlast),
        .block_release  (block_release),
        .s_tready       (s_tready),
        .block_full     (block_full),
        .block          (block)
    );

    luma_block_converter u_converter (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .block_full     (block_full),
        .block          (block),
        .luma_taken     (luma_taken),
        .block_release  (block_release),
        .luma_full      (luma_full),
        .luma           (luma)
    );

    luma_block_serializer u_serializer (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .luma_full      (luma_full),
        .luma           (luma),
        .word_taken     (word_taken),
        .luma_taken     (luma_taken),
        .word_valid     (word_valid),
        .word           (word)
    );

    axis_output_stage u_output (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .word           (word),
        .word_valid     (word_valid),
        .m_tready       (m_tready),
        .word_taken     (word_taken),
        .m_tvalid       (m_tvalid),
        .m_tdata        (m_tdata),
        .m_tlast        (m_tlast)
    );

endmodule

// ==== source/luma_block_converter.sv ====
module luma_block_converter (
    input  logic                M_AXIS_ACLK,
    input  logic                M_AXIS_ARESETN,
    input  logic                block_full,
    input  jpg_pkg::rgb_block_t block,
    input  logic                luma_taken,
    output logic                block_release,
    output logic                luma_full,
    output jpg_pkg::plane_t     luma
);

    jpg_pkg::cv_state_t state;
    logic [$clog2(jpg_pkg::pixel_count)-1:0] idx;
    logic            last_pixel;
    int unsigned     luma_sum;
    jpg_pkg::pixel_t luma_y;

    assign last_pixel = (32'(idx) == jpg_pkg::pixel_count - 1);

    // one weighted sum per cycle, pixel idx
    assign luma_sum = jpg_pkg::luma_coef_r * 32'(block.r[idx])
                    + jpg_pkg::luma_coef_g * 32'(block.g[idx])
                    + jpg_pkg::luma_coef_b * 32'(block.b[idx]);
    assign luma_y = jpg_pkg::pixel_t'(luma_sum >> jpg_pkg::luma_shift);

    // receiver may refill its planes once the last pixel is read
    assign block_release = (state == jpg_pkg::convert) && last_pixel;
    assign luma_full = (state == jpg_pkg::offer);

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            state <= jpg_pkg::idle;
            idx <= '0;
        end else begin
            unique case (state)
                jpg_pkg::idle: begin
                    if (block_full) begin
                        idx <= '0;
                        state <= jpg_pkg::convert;
                    end
                end
                jpg_pkg::convert: begin
                    idx <= idx + 1'b1;
                    if (last_pixel) begin
                        state <= jpg_pkg::offer;
                    end
                end
                default: begin
                    if (luma_taken) begin
                        state <= jpg_pkg::idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (state == jpg_pkg::convert) begin
            luma[idx] <= luma_y;
        end
    end

endmodule

// ==== source/luma_block_serializer.sv ====
module luma_block_serializer (
    input  logic               M_AXIS_ACLK,
    input  logic               M_AXIS_ARESETN,
    input  logic               luma_full,
    input  jpg_pkg::plane_t    luma,
    input  logic               word_taken,
    output logic               luma_taken,
    output logic               word_valid,
    output jpg_pkg::out_word_t word
);

    jpg_pkg::ser_state_t state;
    jpg_pkg::plane_t     held;
    logic [$clog2(jpg_pkg::pixel_count)-1:0] idx;

    // copy as soon as we are empty, which frees the converter
    assign luma_taken = (state == jpg_pkg::empty) && luma_full;
    assign word_valid = (state == jpg_pkg::sending);

    // raster order, luma zero-extended to the stream width
    always_comb begin
        word.data = jpg_pkg::word_t'(held[idx]);
        word.last = (32'(idx) == jpg_pkg::pixel_count - 1);
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            state <= jpg_pkg::empty;
            idx <= '0;
        end else begin
            unique case (state)
                jpg_pkg::empty: begin
                    if (luma_taken) begin
                        idx <= '0;
                        state <= jpg_pkg::sending;
                    end
                end
                default: begin
                    if (word_taken) begin
                        idx <= idx + 1'b1;
                        if (word.last) begin
                            state <= jpg_pkg::empty;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (luma_taken) begin
            held <= luma;
        end
    end

endmodule

// ==== source/rgb_block_receiver.sv ====
module rgb_block_receiver (
    input  logic                M_AXIS_ACLK,
    input  logic                M_AXIS_ARESETN,
    input  jpg_pkg::word_t      s_tdata,
    input  logic                s_tvalid,
    input  logic                s_tlast,
    input  logic                block_release,
    output logic                s_tready,
    output logic                block_full,
    output jpg_pkg::rgb_block_t block
);

    jpg_pkg::rx_state_t    state;
    jpg_pkg::rx_state_t    next_plane;
    jpg_pkg::pixel_index_t count;
    logic                  beat;
    logic                  plane_done;
    logic [jpg_pkg::pixels_per_word-1:0][$clog2(jpg_pkg::pixel_count)-1:0] lane_slot;

    assign s_tready = (state != jpg_pkg::hold);
    assign block_full = (state == jpg_pkg::hold);
    assign beat = s_tvalid && s_tready;

    // full plane, or the sender cut it short with tlast
    assign plane_done = s_tlast ||
        (32'(count) + jpg_pkg::pixels_per_word >= jpg_pkg::pixel_count);

    always_comb begin
        unique case (state)
            jpg_pkg::recv_r: next_plane = jpg_pkg::recv_g;
            jpg_pkg::recv_g: next_plane = jpg_pkg::recv_b;
            default:         next_plane = jpg_pkg::hold;
        endcase
    end

    // target slot of each byte lane, count stays a multiple of four
    always_comb begin
        int lane_pos;
        for (int k = 0; k < jpg_pkg::pixels_per_word; k++) begin
            lane_pos = 32'(count) + k;
            lane_slot[k] = lane_pos[$clog2(jpg_pkg::pixel_count)-1:0];
        end
    end

    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            state <= jpg_pkg::recv_r;
            count <= '0;
        end else begin
            unique case (state)
                jpg_pkg::hold: begin
                    if (block_release) begin
                        state <= jpg_pkg::recv_r;
                    end
                end
                default: begin
                    if (beat) begin
                        if (plane_done) begin
                            count <= '0;
                            state <= next_plane;
                        end else begin
                            count <= count + jpg_pkg::pixel_index_t'(jpg_pkg::pixels_per_word);
                        end
                    end
                end
            endcase
        end
    end

    // unwritten pixels keep the previous block
    always_ff @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            block <= '0;
        end else if (beat) begin
            for (int k = 0; k < jpg_pkg::pixels_per_word; k++) begin
                unique case (state)
                    jpg_pkg::recv_r: block.r[lane_slot[k]] <=
                        s_tdata[k*jpg_pkg::pixel_width +: jpg_pkg::pixel_width];
                    jpg_pkg::recv_g: block.g[lane_slot[k]] <=
                        s_tdata[k*jpg_pkg::pixel_width +: jpg_pkg::pixel_width];
                    default: block.b[lane_slot[k]] <=
                        s_tdata[k*jpg_pkg::pixel_width +: jpg_pkg::pixel_width];
                endcase
            end
        end
    end

endmodule

// ==== src.f ====
+incdir+tb
source/jpg_pkg.sv
source/rgb_block_receiver.sv
source/luma_block_converter.sv
source/luma_block_serializer.sv
source/axis_output_stage.sv
source/jpg_top.sv
tb/tb_jpg.sv

// ==== tb/jpg_tb_model.svh ====
`ifndef JPG_TB_MODEL_SVH
`define JPG_TB_MODEL_SVH

// reference colour planes, [0] is R, [1] is G, [2] is B
logic [7:0] ref_plane [3][jpg_pkg::pixel_count];
int         ref_plane_sel;
int         ref_count;
// luma values the DUT still owes, oldest first
logic [7:0] expected_luma [$];

function automatic logic [7:0] luma_of(input logic [7:0] r, input logic [7:0] g,
                                       input logic [7:0] b);
    int unsigned sum;
    sum = 77 * 32'(r) + 150 * 32'(g) + 29 * 32'(b);
    return 8'(sum >> 8);
endfunction

function automatic void reset_model();
    for (int p = 0; p < 3; p++) begin
        for (int i = 0; i < jpg_pkg::pixel_count; i++) begin
            ref_plane[2'(p)][6'(i)] = 8'h00;
        end
    end
    ref_plane_sel = 0;
    ref_count = 0;
    expected_luma.delete();
endfunction

// one accepted input beat, four bytes into the active plane
function automatic void apply_beat(input logic [31:0] data, input logic last);
    for (int k = 0; k < 4; k++) begin
        if (ref_count + k < jpg_pkg::pixel_count) begin
            ref_plane[2'(ref_plane_sel)][6'(ref_count + k)] = 8'(data >> (8 * k));
        end
    end
    if (last || ref_count + 4 >= jpg_pkg::pixel_count) begin
        ref_count = 0;
        ref_plane_sel++;
        if (ref_plane_sel == 3) begin
            for (int i = 0; i < jpg_pkg::pixel_count; i++) begin
                expected_luma.push_back(luma_of(ref_plane[0][6'(i)], ref_plane[1][6'(i)],
                                                ref_plane[2][6'(i)]));
            end
            ref_plane_sel = 0;
        end
    end else begin
        ref_count += 4;
    end
endfunction

`endif

// ==== tb/tb_jpg.sv ====
module tb_jpg;

    localparam int half_period = 50;
    localparam int clock_period = 2 * half_period;
    localparam int reset_cycles = 16;
    localparam int block_count = 8;
    localparam int total_words = block_count * jpg_pkg::pixel_count;
    localparam int timeout_cycles = reset_cycles + jpg_pkg::start_delay + block_count * 400;

    logic           M_AXIS_ACLK;
    logic           M_AXIS_ARESETN;
    jpg_pkg::word_t s_tdata;
    logic           s_tvalid;
    logic           s_tlast;
    logic           m_tready;
    logic           s_tready;
    logic           m_tvalid;
    jpg_pkg::word_t m_tdata;
    logic           m_tlast;

    jpg_pkg::word_t beat_data [$];
    logic           beat_last [$];
    int             beat_ptr;
    int             words_seen;
    logic           stalled;
    jpg_pkg::word_t held_data;
    logic           held_last;
    logic [7:0]     exp_y;

    `include "jpg_tb_model.svh"

    jpg_top UUT (
        .M_AXIS_ACLK    (M_AXIS_ACLK),
        .M_AXIS_ARESETN (M_AXIS_ARESETN),
        .s_tdata        (s_tdata),
        .s_tvalid       (s_tvalid),
        .s_tlast        (s_tlast),
        .m_tready       (m_tready),
        .s_tready       (s_tready),
        .m_tvalid       (m_tvalid),
        .m_tdata        (m_tdata),
        .m_tlast        (m_tlast)
    );

    always #half_period M_AXIS_ACLK = ~M_AXIS_ACLK;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // block 0 cuts G short so zero pixels after reset show up in the luma
    task automatic build_stimulus();
        int   beats;
        logic early;
        for (int b = 0; b < block_count; b++) begin
            for (int p = 0; p < 3; p++) begin
                early = (b == 0 && p == 1) || (b >= 2 && $urandom_range(0, 3) == 0);
                beats = early ? int'($urandom_range(1, 15)) : 16;
                for (int n = 0; n < beats; n++) begin
                    beat_data.push_back($urandom());
                    beat_last.push_back(early && n == beats - 1);
                end
            end
        end
    endtask

    // input driver, holds a word until the DUT takes it
    always @(posedge M_AXIS_ACLK) begin
        if (!M_AXIS_ARESETN) begin
            s_tvalid <= 1'b0;
            s_tlast <= 1'b0;
            m_tready <= 1'b0;
        end else begin
            m_tready <= ($urandom_range(0, 3) != 0);
            if (s_tvalid && s_tready) begin
                apply_beat(s_tdata, s_tlast);
                beat_ptr++;
            end
            if (!s_tvalid || s_tready) begin
                if (beat_ptr < beat_data.size() && $urandom_range(0, 3) != 0) begin
                    s_tvalid <= 1'b1;
                    s_tdata <= beat_data[beat_ptr];
                    s_tlast <= beat_last[beat_ptr];
                end else begin
                    s_tvalid <= 1'b0;
                    s_tlast <= 1'b0;
                end
            end
        end
    end

    // output monitor
    always @(posedge M_AXIS_ACLK) begin
        if (M_AXIS_ARESETN) begin
            if (stalled) begin
                check_value(32'(m_tvalid), 32'd1, "m_tvalid dropped during a stall");
                check_value(m_tdata, held_data, "m_tdata changed during a stall");
                check_value(32'(m_tlast), 32'(held_last), "m_tlast changed during a stall");
            end
            if (m_tvalid && m_tready) begin
                if (expected_luma.size() == 0) begin
                    $display("Checks failed");
                    $fatal(1, "an output word arrived with no block outstanding");
                end else begin
                    exp_y = expected_luma.pop_front();
                    check_value(m_tdata, 32'(exp_y), "m_tdata");
                    check_value(32'(m_tlast), 32'(words_seen % 64 == 63), "m_tlast");
                    words_seen++;
                end
            end
            stalled = m_tvalid && !m_tready;
            held_data = m_tdata;
            held_last = m_tlast;
        end
    end

    initial begin
        void'($urandom(60080));
        M_AXIS_ACLK = 1'b0;
        M_AXIS_ARESETN = 1'b0;
        s_tdata = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        m_tready = 1'b0;
        beat_ptr = 0;
        words_seen = 0;
        stalled = 1'b0;
        reset_model();
        build_stimulus();
        repeat (reset_cycles) @(posedge M_AXIS_ACLK);
        M_AXIS_ARESETN <= 1'b1;
        wait (words_seen == total_words);
        repeat (4) @(posedge M_AXIS_ACLK);
        // pipeline drained, receiver open for the next block
        check_value(32'(s_tready), 32'd1, "s_tready after the last block");
        check_value(32'(m_tvalid), 32'd0, "m_tvalid after the last block");
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(timeout_cycles * clock_period);
        $display("Checks failed");
        $fatal(1, "timeout, the DUT did not deliver all output words in time");
    end

endmodule
